// File: files.f
+incdir+.
pbus_pkg.sv
pbus_reg_if.sv
pbus_decoder.sv
pbus_timer.sv
pbus_gpio.sv
peripheral_bus.sv
tb_peripheral_bus.sv

// File: Bender.yml
package:
  name: peripheral_bus

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - pbus_pkg.sv
      - pbus_reg_if.sv
      - pbus_decoder.sv
      - pbus_timer.sv
      - pbus_gpio.sv
      - peripheral_bus.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_peripheral_bus.sv

// File: tb_peripheral_bus.sv
// self-checking testbench that runs a stimulus table through the wishbone port of peripheral_bus
`timescale 1ns/10ps
`include "pbus_defines.svh"

module tb_peripheral_bus;

    localparam int WB_TIMEOUT  = 20;        // cycles to wait for ack or err
    localparam int IRQ_TIMEOUT = 100;       // cycles to wait for an interrupt

    typedef enum {OP_WR, OP_RD, OP_PIN, OP_WAIT_IRQ, OP_CHK_IRQ, OP_CHK_OUT} op_e;

    typedef struct {
        op_e                  op;
        int                   grp;          // behavior number
        pbus_pkg::pbus_addr_t addr;
        pbus_pkg::pbus_data_t wdata;        // write data, pin value or irq mask
        pbus_pkg::pbus_data_t exp;
        logic                 exp_err;
    } step_t;

    logic                            pbus_clock_i;
    logic                            reset_i;
    logic                            wb_cyc_i;
    logic                            wb_stb_i;
    logic                            wb_we_i;
    pbus_pkg::pbus_addr_t            wb_adr_i;
    pbus_pkg::pbus_data_t            wb_dat_i;
    pbus_pkg::pbus_data_t            wb_dat_o;
    logic                            wb_ack_o;
    logic                            wb_err_o;
    logic [`PBUS_GPIO_IN_WIDTH-1:0]  gpio_in_i;
    logic [`PBUS_GPIO_OUT_WIDTH-1:0] gpio_out_o;
    pbus_pkg::irq_vec_t              int_o;

    step_t       steps[$];                  // stimulus table
    logic [31:0] lfsr_q = 32'hb21a6edf;
    logic        test_ok;
    int          pass_count = 0;
    int          fail_count = 0;

    peripheral_bus uut (.*);

    always #4 pbus_clock_i = ~pbus_clock_i;    // 8 ns period

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(output logic [7:0] v);
        v = '0;
        for (int i = 0; i < 8; i++) begin
            v      = {v[6:0], lfsr_q[31]};  // one step per bit
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic pbus_pkg::pbus_addr_t make_addr(input int sel, input int idx);
        return pbus_pkg::pbus_addr_t'((sel << `PBUS_SEL_LSB) | (idx << `PBUS_REG_LSB));
    endfunction

    task automatic add_step(input op_e op, input int grp, input pbus_pkg::pbus_addr_t addr,
                            input pbus_pkg::pbus_data_t wdata, input pbus_pkg::pbus_data_t exp,
                            input logic exp_err = 1'b0);
        step_t s;
        s = '{op, grp, addr, wdata, exp, exp_err};
        steps.push_back(s);
    endtask

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_data(input pbus_pkg::pbus_data_t got, input pbus_pkg::pbus_data_t exp);
        if (got !== exp) begin
            $display("ERR %0t: data 0x%08h, expected 0x%08h", $time, got, exp);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_resp(input logic got_err, input logic exp_err);
        if (got_err !== exp_err) begin
            $display("ERR %0t: response was %s, expected %s", $time,
                     got_err ? "err" : "ack", exp_err ? "err" : "ack");
            test_ok = 1'b0;
        end
    endtask

    task automatic check_irq(input pbus_pkg::irq_vec_t got, input pbus_pkg::irq_vec_t exp);
        if (got !== exp) begin
            $display("ERR %0t: int_o 3'b%03b, expected 3'b%03b", $time, got, exp);
            test_ok = 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // bus and step execution
    ////////////////////////////////////////////////////////////

    // one classic cycle started 1 ns after a rising edge
    task automatic wb_access(input logic we, input pbus_pkg::pbus_addr_t adr,
                             input pbus_pkg::pbus_data_t wdat,
                             output pbus_pkg::pbus_data_t rdat, output logic err);
        int   n;
        logic got;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        got  = 1'b0;
        err  = 1'b0;
        rdat = '0;
        n    = 0;
        while (!got && n < WB_TIMEOUT) begin
            @(posedge pbus_clock_i);
            #1;
            n++;
            if (wb_ack_o || wb_err_o) begin
                got  = 1'b1;
                err  = wb_err_o;
                rdat = wb_dat_o;
            end
        end
        wb_cyc_i = 1'b0;                    // end of cycle
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        if (!got) begin
            $display("no acknowledge arrived within %0d cycles at address 0x%03h",
                     WB_TIMEOUT, adr);
            test_ok = 1'b0;
        end
    endtask

    task automatic run_step(input step_t s);
        pbus_pkg::pbus_data_t rdat;
        logic                 err;
        int                   n;
        case (s.op)
            OP_WR, OP_RD: begin
                wb_access(s.op == OP_WR, s.addr, s.wdata, rdat, err);
                check_resp(err, s.exp_err);
                if (s.op == OP_RD || s.exp_err) begin
                    check_data(rdat, s.exp);    // write data only on the error path
                end
            end
            OP_PIN: begin
                gpio_in_i = s.wdata[`PBUS_GPIO_IN_WIDTH-1:0];
                repeat (3) @(posedge pbus_clock_i);   // sync plus change flag
                #1;
            end
            OP_WAIT_IRQ: begin
                n = 0;
                while (((int_o & s.wdata[`PBUS_NUM_IRQ-1:0]) == '0) && n < IRQ_TIMEOUT) begin
                    @(posedge pbus_clock_i);
                    #1;
                    n++;
                end
                if ((int_o & s.wdata[`PBUS_NUM_IRQ-1:0]) == '0) begin
                    $display("interrupt mask 3'b%03b never rose within %0d cycles",
                             s.wdata[`PBUS_NUM_IRQ-1:0], IRQ_TIMEOUT);
                    test_ok = 1'b0;
                end
                check_irq(int_o, s.exp[`PBUS_NUM_IRQ-1:0]);
            end
            OP_CHK_IRQ: check_irq(int_o, s.exp[`PBUS_NUM_IRQ-1:0]);
            OP_CHK_OUT: check_data(pbus_pkg::pbus_data_t'(gpio_out_o), s.exp);
            default: ;
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // table and main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [7:0]           pins;
        pbus_pkg::pbus_data_t ctrl_one;
        pbus_pkg::pbus_data_t ctrl_auto;
        pbus_clock_i = 1'b0;
        reset_i      = 1'b1;
        wb_cyc_i     = 1'b0;
        wb_stb_i     = 1'b0;
        wb_we_i      = 1'b0;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        gpio_in_i    = '0;

        draw_bits(pins);
        for (int i = 0; i < 8 && pins == 8'h00; i++) begin
            draw_bits(pins);                // need at least one changing pin
        end
        ctrl_one  = (1 << pbus_pkg::TIM_CTRL_EN_BIT) | (1 << pbus_pkg::TIM_CTRL_IRQ_EN_BIT);
        ctrl_auto = ctrl_one | (1 << pbus_pkg::TIM_CTRL_RELOAD_BIT);

        add_step(OP_CHK_IRQ, 1, '0, '0, '0);
        add_step(OP_CHK_OUT, 1, '0, '0, '0);
        for (int p = 0; p < 3; p++) begin
            for (int r = 0; r < 4; r++) begin
                add_step(OP_RD, 1, make_addr(p, r), '0, '0);
            end
        end
        add_step(OP_WR, 2, make_addr(pbus_pkg::PERIPH_GPIO, pbus_pkg::GPIO_OUT), 32'h123456a5, '0);
        add_step(OP_CHK_OUT, 2, '0, '0, 32'ha5);
        add_step(OP_RD, 2, make_addr(pbus_pkg::PERIPH_GPIO, pbus_pkg::GPIO_OUT), '0, 32'ha5);
        // gpio input toggles every set pin away from its reset value
        add_step(OP_PIN, 3, '0, pins, '0);
        add_step(OP_RD, 3, make_addr(pbus_pkg::PERIPH_GPIO, pbus_pkg::GPIO_IN), '0, pins);
        add_step(OP_RD, 3, make_addr(pbus_pkg::PERIPH_GPIO, pbus_pkg::GPIO_STATUS), '0, pins);
        add_step(OP_CHK_IRQ, 3, '0, '0, '0);
        add_step(OP_WR, 3, make_addr(pbus_pkg::PERIPH_GPIO, pbus_pkg::GPIO_IRQ_EN), 32'hff, '0);
        add_step(OP_WAIT_IRQ, 3, '0, 32'b001, 32'b001);
        add_step(OP_WR, 3, make_addr(pbus_pkg::PERIPH_GPIO, pbus_pkg::GPIO_STATUS), 32'hff, '0);
        add_step(OP_RD, 3, make_addr(pbus_pkg::PERIPH_GPIO, pbus_pkg::GPIO_STATUS), '0, '0);
        add_step(OP_CHK_IRQ, 3, '0, '0, '0);
        // timer 0 one shot
        add_step(OP_WR, 4, make_addr(pbus_pkg::PERIPH_TIM0, pbus_pkg::TIM_LOAD), 32'd5, '0);
        add_step(OP_WR, 4, make_addr(pbus_pkg::PERIPH_TIM0, pbus_pkg::TIM_CTRL), ctrl_one, '0);
        add_step(OP_WAIT_IRQ, 4, '0, 32'b010, 32'b010);
        add_step(OP_RD, 4, make_addr(pbus_pkg::PERIPH_TIM0, pbus_pkg::TIM_CTRL), '0,
                 ctrl_one & ~(32'd1 << pbus_pkg::TIM_CTRL_EN_BIT));
        add_step(OP_RD, 4, make_addr(pbus_pkg::PERIPH_TIM0, pbus_pkg::TIM_STATUS), '0, 32'd1);
        add_step(OP_WR, 4, make_addr(pbus_pkg::PERIPH_TIM0, pbus_pkg::TIM_STATUS), 32'd1, '0);
        add_step(OP_CHK_IRQ, 4, '0, '0, '0);
        // timer 1 periodic over 41 cycles so the clear is seen before the next expiry
        add_step(OP_WR, 5, make_addr(pbus_pkg::PERIPH_TIM1, pbus_pkg::TIM_LOAD), 32'd40, '0);
        add_step(OP_WR, 5, make_addr(pbus_pkg::PERIPH_TIM1, pbus_pkg::TIM_CTRL), ctrl_auto, '0);
        add_step(OP_WAIT_IRQ, 5, '0, 32'b100, 32'b100);
        add_step(OP_WR, 5, make_addr(pbus_pkg::PERIPH_TIM1, pbus_pkg::TIM_STATUS), 32'd1, '0);
        add_step(OP_CHK_IRQ, 5, '0, '0, '0);
        add_step(OP_WAIT_IRQ, 5, '0, 32'b100, 32'b100);
        add_step(OP_RD, 5, make_addr(pbus_pkg::PERIPH_TIM1, pbus_pkg::TIM_CTRL), '0, ctrl_auto);
        add_step(OP_WR, 5, make_addr(pbus_pkg::PERIPH_TIM1, pbus_pkg::TIM_CTRL), '0, '0);
        add_step(OP_WR, 5, make_addr(pbus_pkg::PERIPH_TIM1, pbus_pkg::TIM_STATUS), 32'd1, '0);
        add_step(OP_CHK_IRQ, 5, '0, '0, '0);
        // holes in the map
        add_step(OP_RD, 6, make_addr(3, 0), '0, `PBUS_UNMAPPED_DATA, 1'b1);
        add_step(OP_WR, 6, make_addr(3, 0), 32'hffffffff, `PBUS_UNMAPPED_DATA, 1'b1);
        add_step(OP_WR, 6, make_addr(15, 1), 32'hffffffff, `PBUS_UNMAPPED_DATA, 1'b1);
        add_step(OP_RD, 6, make_addr(pbus_pkg::PERIPH_GPIO, pbus_pkg::GPIO_OUT), '0, 32'ha5);
        add_step(OP_RD, 6, make_addr(pbus_pkg::PERIPH_TIM0, pbus_pkg::TIM_CTRL), '0,
                 ctrl_one & ~(32'd1 << pbus_pkg::TIM_CTRL_EN_BIT));
        add_step(OP_RD, 6, make_addr(pbus_pkg::PERIPH_TIM0, pbus_pkg::TIM_LOAD), '0, 32'd5);
        add_step(OP_RD, 6, make_addr(pbus_pkg::PERIPH_TIM1, pbus_pkg::TIM_CTRL), '0, '0);
        add_step(OP_RD, 6, make_addr(pbus_pkg::PERIPH_TIM1, pbus_pkg::TIM_LOAD), '0, 32'd40);
        add_step(OP_CHK_OUT, 6, '0, '0, 32'ha5);

        repeat (5) @(posedge pbus_clock_i);
        #1;
        reset_i = 1'b0;

        foreach (steps[i]) begin
            test_ok = 1'b1;
            run_step(steps[i]);
            $display("test %0d behavior %0d %s addr 0x%03h: %s", i, steps[i].grp,
                     steps[i].op.name(), steps[i].addr, test_ok ? "ok" : "failed");
            if (test_ok) begin
                pass_count++;
            end else begin
                fail_count++;
            end
        end

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule : tb_peripheral_bus

// File: peripheral_bus.sv
// top of the peripheral bus, wishbone slave port in front of gpio and two timers
`timescale 1ns/10ps
`include "pbus_defines.svh"

module peripheral_bus (
    input  logic                            pbus_clock_i,
    input  logic                            reset_i,

    // wishbone classic slave
    input  logic                            wb_cyc_i,
    input  logic                            wb_stb_i,
    input  logic                            wb_we_i,
    input  pbus_pkg::pbus_addr_t            wb_adr_i,
    input  pbus_pkg::pbus_data_t            wb_dat_i,
    output pbus_pkg::pbus_data_t            wb_dat_o,
    output logic                            wb_ack_o,
    output logic                            wb_err_o,

    // pins
    input  logic [`PBUS_GPIO_IN_WIDTH-1:0]  gpio_in_i,
    output logic [`PBUS_GPIO_OUT_WIDTH-1:0] gpio_out_o,
    output pbus_pkg::irq_vec_t              int_o
);

    ////////////////////////////////////////////////////////////
    // register channels and interrupt sources
    ////////////////////////////////////////////////////////////

    pbus_reg_if gpio_bus ();
    pbus_reg_if tim0_bus ();
    pbus_reg_if tim1_bus ();

    logic gpio_irq;
    logic tim0_irq;
    logic tim1_irq;

    ////////////////////////////////////////////////////////////
    // blocks
    ////////////////////////////////////////////////////////////

    pbus_decoder decoder_u (
        .pbus_clock_i ( pbus_clock_i ),
        .reset_i      ( reset_i      ),
        .wb_cyc_i     ( wb_cyc_i     ),
        .wb_stb_i     ( wb_stb_i     ),
        .wb_we_i      ( wb_we_i      ),
        .wb_adr_i     ( wb_adr_i     ),
        .wb_dat_i     ( wb_dat_i     ),
        .wb_dat_o     ( wb_dat_o     ),
        .wb_ack_o     ( wb_ack_o     ),
        .wb_err_o     ( wb_err_o     ),
        .gpio_o       ( gpio_bus     ),
        .tim0_o       ( tim0_bus     ),
        .tim1_o       ( tim1_bus     )
    );

    pbus_gpio gpio_u (
        .pbus_clock_i ( pbus_clock_i ),
        .reset_i      ( reset_i      ),
        .bus_i        ( gpio_bus     ),
        .gpio_in_i    ( gpio_in_i    ),
        .gpio_out_o   ( gpio_out_o   ),
        .irq_o        ( gpio_irq     )
    );

    pbus_timer tim0_u (
        .pbus_clock_i ( pbus_clock_i ),
        .reset_i      ( reset_i      ),
        .bus_i        ( tim0_bus     ),
        .irq_o        ( tim0_irq     )
    );

    pbus_timer tim1_u (
        .pbus_clock_i ( pbus_clock_i ),
        .reset_i      ( reset_i      ),
        .bus_i        ( tim1_bus     ),
        .irq_o        ( tim1_irq     )
    );

    // fixed positions in the interrupt vector
    always_comb begin
        int_o                     = '0;
        int_o[pbus_pkg::IRQ_GPIO] = gpio_irq;
        int_o[pbus_pkg::IRQ_TIM0] = tim0_irq;
        int_o[pbus_pkg::IRQ_TIM1] = tim1_irq;
    end

endmodule : peripheral_bus

// File: pbus_gpio.sv
// gpio block with output register, synchronised inputs and change interrupt
`timescale 1ns/10ps
`include "pbus_defines.svh"

module pbus_gpio (
    input  logic                            pbus_clock_i,
    input  logic                            reset_i,
    pbus_reg_if.periph                      bus_i,        // register channel
    input  logic [`PBUS_GPIO_IN_WIDTH-1:0]  gpio_in_i,    // async pins
    output logic [`PBUS_GPIO_OUT_WIDTH-1:0] gpio_out_o,   // driven pins
    output logic                            irq_o         // any enabled change
);

    localparam int unsigned IN_W  = `PBUS_GPIO_IN_WIDTH;
    localparam int unsigned OUT_W = `PBUS_GPIO_OUT_WIDTH;

    logic [OUT_W-1:0]     out_q;      // pin drive
    logic [IN_W-1:0]      meta_q;     // first sync stage
    logic [IN_W-1:0]      sync_q;     // GPIO_IN value
    logic [IN_W-1:0]      prev_q;     // last sync value
    logic [IN_W-1:0]      irq_en_q;   // per bit mask
    logic [IN_W-1:0]      pending_q;  // per bit change flag
    logic [IN_W-1:0]      change;     // edge on sync value
    logic [IN_W-1:0]      clr_mask;   // w1c bits this cycle
    logic                 wr_en;
    pbus_pkg::gpio_reg_e  reg_sel;
    pbus_pkg::pbus_data_t rdata;

    assign reg_sel  = pbus_pkg::gpio_reg_e'(bus_i.idx);
    assign wr_en    = bus_i.req & bus_i.we;
    assign change   = sync_q ^ prev_q;
    assign clr_mask = (wr_en && reg_sel == pbus_pkg::GPIO_STATUS) ? bus_i.wdata[IN_W-1:0] : '0;

    ////////////////////////////////////////////////////////////
    // input path
    ////////////////////////////////////////////////////////////

    always_ff @(posedge pbus_clock_i) begin
        if (reset_i) begin
            meta_q    <= '0;
            sync_q    <= '0;
            prev_q    <= '0;
            pending_q <= '0;
        end else begin
            meta_q    <= gpio_in_i;     // two flop sync
            sync_q    <= meta_q;
            prev_q    <= sync_q;        // change reference
            pending_q <= (pending_q & ~clr_mask) | change;  // set wins
        end
    end

    ////////////////////////////////////////////////////////////
    // writable registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge pbus_clock_i) begin
        if (reset_i) begin
            out_q    <= '0;
            irq_en_q <= '0;
        end else if (wr_en) begin
            case (reg_sel)
                pbus_pkg::GPIO_OUT:    out_q    <= bus_i.wdata[OUT_W-1:0];
                pbus_pkg::GPIO_IRQ_EN: irq_en_q <= bus_i.wdata[IN_W-1:0];
                default: ;                          // in ro, status w1c
            endcase
        end
    end

    always_comb begin
        rdata = '0;
        case (reg_sel)
            pbus_pkg::GPIO_OUT:    rdata[OUT_W-1:0] = out_q;
            pbus_pkg::GPIO_IN:     rdata[IN_W-1:0]  = sync_q;
            pbus_pkg::GPIO_IRQ_EN: rdata[IN_W-1:0]  = irq_en_q;
            pbus_pkg::GPIO_STATUS: rdata[IN_W-1:0]  = pending_q;
            default:               rdata = '0;
        endcase
    end

    assign bus_i.rdata = rdata;
    assign gpio_out_o  = out_q;
    assign irq_o       = |(pending_q & irq_en_q);

    // every newly set pending bit traces back to a sync edge one cycle before
    assert property (@(posedge pbus_clock_i) disable iff (reset_i)
        (pending_q & ~$past(pending_q) & ~$past(sync_q ^ prev_q)) == '0);

endmodule : pbus_gpio

// File: pbus_timer.sv
// down-counting timer with load, auto-reload and interrupt, instantiated once per timer
`timescale 1ns/10ps

module pbus_timer (
    input  logic        pbus_clock_i,
    input  logic        reset_i,
    pbus_reg_if.periph  bus_i,         // register channel from the decoder
    output logic        irq_o          // pending and enabled
);

    localparam int unsigned EN_BIT     = pbus_pkg::TIM_CTRL_EN_BIT;
    localparam int unsigned RELOAD_BIT = pbus_pkg::TIM_CTRL_RELOAD_BIT;
    localparam int unsigned IRQ_EN_BIT = pbus_pkg::TIM_CTRL_IRQ_EN_BIT;
    localparam int unsigned CTRL_WIDTH = IRQ_EN_BIT + 1;

    logic [CTRL_WIDTH-1:0]  ctrl_q;    // en, reload, irq en
    pbus_pkg::pbus_data_t   load_q;    // reload value
    pbus_pkg::pbus_data_t   count_q;   // running count
    logic                   pending_q; // expiry seen
    logic                   wr_en;     // bus write this cycle
    logic                   expire;    // count hits zero while running
    pbus_pkg::timer_reg_e   reg_sel;   // addressed register
    pbus_pkg::pbus_data_t   rdata;     // read mux

    assign reg_sel = pbus_pkg::timer_reg_e'(bus_i.idx);
    assign wr_en   = bus_i.req & bus_i.we;
    assign expire  = ctrl_q[EN_BIT] && (count_q == '0);

    ////////////////////////////////////////////////////////////
    // counter and control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge pbus_clock_i) begin
        if (reset_i) begin
            ctrl_q  <= '0;
            load_q  <= '0;
            count_q <= '0;
        end else begin
            if (expire) begin
                if (ctrl_q[RELOAD_BIT]) begin
                    count_q <= load_q;          // periodic mode
                end else begin
                    ctrl_q[EN_BIT] <= 1'b0;     // one shot, stop
                end
            end else if (ctrl_q[EN_BIT]) begin
                count_q <= count_q - 1'b1;
            end
            // bus writes override the count step
            if (wr_en) begin
                case (reg_sel)
                    pbus_pkg::TIM_CTRL: begin
                        ctrl_q <= bus_i.wdata[CTRL_WIDTH-1:0];
                        if (bus_i.wdata[EN_BIT]) begin
                            count_q <= load_q;  // start from load
                        end
                    end
                    pbus_pkg::TIM_LOAD: begin
                        load_q <= bus_i.wdata;
                        if (ctrl_q[EN_BIT]) begin
                            count_q <= bus_i.wdata;  // restart period
                        end
                    end
                    default: ;                  // count ro, status below
                endcase
            end
        end
    end

    // pending, a new expiry wins over the clear
    always_ff @(posedge pbus_clock_i) begin
        if (reset_i) begin
            pending_q <= 1'b0;
        end else if (expire) begin
            pending_q <= 1'b1;
        end else if (wr_en && reg_sel == pbus_pkg::TIM_STATUS && bus_i.wdata[0]) begin
            pending_q <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // read back and interrupt
    ////////////////////////////////////////////////////////////

    always_comb begin
        rdata = '0;
        case (reg_sel)
            pbus_pkg::TIM_CTRL:   rdata[CTRL_WIDTH-1:0] = ctrl_q;
            pbus_pkg::TIM_LOAD:   rdata = load_q;
            pbus_pkg::TIM_COUNT:  rdata = count_q;
            pbus_pkg::TIM_STATUS: rdata[0] = pending_q;
            default:              rdata = '0;
        endcase
    end

    assign bus_i.rdata = rdata;
    assign irq_o       = pending_q & ctrl_q[IRQ_EN_BIT];

    // count stays inside the loaded period while running
    assert property (@(posedge pbus_clock_i) disable iff (reset_i)
        ctrl_q[EN_BIT] |-> (count_q <= load_q));

endmodule : pbus_timer

// File: pbus_decoder.sv
// wishbone classic slave that decodes the address and routes each access to one peripheral
`timescale 1ns/10ps
`include "pbus_defines.svh"

module pbus_decoder (
    input  logic                 pbus_clock_i,
    input  logic                 reset_i,

    // wishbone classic slave
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  pbus_pkg::pbus_addr_t wb_adr_i,
    input  pbus_pkg::pbus_data_t wb_dat_i,
    output pbus_pkg::pbus_data_t wb_dat_o,
    output logic                 wb_ack_o,
    output logic                 wb_err_o,

    // register channels
    pbus_reg_if.ctrl             gpio_o,
    pbus_reg_if.ctrl             tim0_o,
    pbus_reg_if.ctrl             tim1_o
);

    ////////////////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////////////////

    logic                  access;     // new request this cycle
    logic                  mapped;     // select hits a peripheral
    pbus_pkg::periph_sel_e sel;        // decoded select field
    pbus_pkg::reg_idx_t    idx;        // register index field
    pbus_pkg::pbus_data_t  rdata_mux;  // selected read data

    // open request masked while a response is on the bus
    assign access = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~wb_err_o;

    assign sel = pbus_pkg::periph_sel_e'(wb_adr_i[`PBUS_SEL_MSB:`PBUS_SEL_LSB]);
    assign idx = wb_adr_i[`PBUS_REG_MSB:`PBUS_REG_LSB];   // word index

    // only the selected slave sees req
    assign gpio_o.req = access & (sel == pbus_pkg::PERIPH_GPIO);
    assign tim0_o.req = access & (sel == pbus_pkg::PERIPH_TIM0);
    assign tim1_o.req = access & (sel == pbus_pkg::PERIPH_TIM1);

    // shared request fields qualified by req in each slave
    assign gpio_o.we    = wb_we_i;
    assign gpio_o.idx   = idx;
    assign gpio_o.wdata = wb_dat_i;
    assign tim0_o.we    = wb_we_i;
    assign tim0_o.idx   = idx;
    assign tim0_o.wdata = wb_dat_i;
    assign tim1_o.we    = wb_we_i;
    assign tim1_o.idx   = idx;
    assign tim1_o.wdata = wb_dat_i;

    ////////////////////////////////////////////////////////////
    // read mux and response
    ////////////////////////////////////////////////////////////

    always_comb begin
        mapped    = 1'b1;
        rdata_mux = '0;
        case (sel)
            pbus_pkg::PERIPH_GPIO: rdata_mux = gpio_o.rdata;
            pbus_pkg::PERIPH_TIM0: rdata_mux = tim0_o.rdata;
            pbus_pkg::PERIPH_TIM1: rdata_mux = tim1_o.rdata;
            default:               mapped    = 1'b0;    // hole in the map
        endcase
    end

    // single cycle response
    always_ff @(posedge pbus_clock_i) begin
        if (reset_i) begin
            wb_ack_o <= 1'b0;
            wb_err_o <= 1'b0;
        end else begin
            wb_ack_o <= access & mapped;
            wb_err_o <= access & ~mapped;
        end
    end

    // data word captured with the response
    always_ff @(posedge pbus_clock_i) begin
        if (reset_i) begin
            wb_dat_o <= '0;
        end else if (access) begin
            wb_dat_o <= mapped ? rdata_mux : `PBUS_UNMAPPED_DATA;
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // ack and err are exclusive
    assert property (@(posedge pbus_clock_i) disable iff (reset_i)
        !(wb_ack_o && wb_err_o));

    // a response only answers a request held in the cycle before
    assert property (@(posedge pbus_clock_i) disable iff (reset_i)
        (wb_ack_o || wb_err_o) |-> $past(wb_cyc_i && wb_stb_i));

endmodule : pbus_decoder

// File: pbus_reg_if.sv
// register access channel from the bus decoder to one peripheral, one instance per slave
`timescale 1ns/10ps

interface pbus_reg_if;

    logic                 req;     // one cycle per access
    logic                 we;      // write when set with req
    pbus_pkg::reg_idx_t   idx;     // register index
    pbus_pkg::pbus_data_t wdata;   // write data
    pbus_pkg::pbus_data_t rdata;   // comb from idx, same cycle

    // decoder side
    modport ctrl (
        output req,
        output we,
        output idx,
        output wdata,
        input  rdata
    );

    // peripheral side
    modport periph (
        input  req,
        input  we,
        input  idx,
        input  wdata,
        output rdata
    );

endinterface : pbus_reg_if

// File: pbus_pkg.sv
// shared types and register encodings of the peripheral bus, referenced as pbus_pkg::name
`include "pbus_defines.svh"

package pbus_pkg;

    ////////////////////////////////////////////////////////////
    // bus words
    ////////////////////////////////////////////////////////////

    typedef logic [`PBUS_DATA_WIDTH-1:0]              pbus_data_t;  // one data word
    typedef logic [`PBUS_ADDR_WIDTH-1:0]              pbus_addr_t;  // byte address
    typedef logic [`PBUS_REG_MSB-`PBUS_REG_LSB:0]     reg_idx_t;    // register in a peripheral

    // select field, values 3..15 fall in the unmapped hole
    typedef enum logic [`PBUS_SEL_MSB-`PBUS_SEL_LSB:0] {
        PERIPH_GPIO = 4'd0,
        PERIPH_TIM0 = 4'd1,
        PERIPH_TIM1 = 4'd2
    } periph_sel_e;

    ////////////////////////////////////////////////////////////
    // register maps
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        TIM_CTRL   = 2'd0,    // enable, auto-reload, irq enable
        TIM_LOAD   = 2'd1,    // reload value
        TIM_COUNT  = 2'd2,    // current count, read only
        TIM_STATUS = 2'd3     // pending, write one to clear
    } timer_reg_e;

    typedef enum logic [1:0] {
        GPIO_OUT    = 2'd0,   // pin drive
        GPIO_IN     = 2'd1,   // synchronised pins, read only
        GPIO_IRQ_EN = 2'd2,   // per bit mask
        GPIO_STATUS = 2'd3    // per bit pending, w1c
    } gpio_reg_e;

    // bit positions of the timer control register
    localparam int unsigned TIM_CTRL_EN_BIT     = 0;
    localparam int unsigned TIM_CTRL_RELOAD_BIT = 1;
    localparam int unsigned TIM_CTRL_IRQ_EN_BIT = 2;

    ////////////////////////////////////////////////////////////
    // interrupts
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        IRQ_GPIO = 2'd0,
        IRQ_TIM0 = 2'd1,
        IRQ_TIM1 = 2'd2
    } irq_idx_e;

    typedef logic [`PBUS_NUM_IRQ-1:0] irq_vec_t;

endpackage : pbus_pkg

// File: pbus_defines.svh
// bus widths, address map and gpio sizes for the peripheral bus, include where needed
`ifndef PBUS_DEFINES_SVH
`define PBUS_DEFINES_SVH

////////////////////////////////////////////////////////////
// wishbone port
////////////////////////////////////////////////////////////

`define PBUS_DATA_WIDTH      32            // full word accesses only
`define PBUS_ADDR_WIDTH      12            // byte address

////////////////////////////////////////////////////////////
// address map
////////////////////////////////////////////////////////////

`define PBUS_SEL_MSB         11            // peripheral select field
`define PBUS_SEL_LSB         8
`define PBUS_REG_MSB         3             // register index in a peripheral
`define PBUS_REG_LSB         2             // word aligned

// returned with wb_err_o on a hole in the map
`define PBUS_UNMAPPED_DATA   32'hdeadbeef

////////////////////////////////////////////////////////////
// gpio and interrupts
////////////////////////////////////////////////////////////

`define PBUS_GPIO_OUT_WIDTH  8             // output pins
`define PBUS_GPIO_IN_WIDTH   8             // input pins
`define PBUS_NUM_IRQ         3             // gpio, tim0, tim1

`endif
